//--- Makefile
VERILATOR ?= verilator
TOP       := tb_ahb_apb_bridge
FILELIST  := ahb_apb_bridge.f
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(SIM_LOG)
	@grep -q "^SIMULATION PASSED$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- ahb_apb_bridge.f
+incdir+design
design/bridge_pkg.sv
design/ahb_capture.sv
design/apb_sequencer.sv
design/apb_port_mux.sv
design/ahb_apb_bridge.sv
verification/tb_ahb_apb_bridge.sv

//--- design/ahb_apb_bridge.sv
// Top level of the AHB-to-APB bridge; connects the AHB capture, APB sequencer and slave port mux
`timescale 1ns/100ps
`include "bridge_settings.svh"

module ahb_apb_bridge (
  input  logic                          hclk28,
  input  logic                          hreset_n28,

  // AHB slave interface
  input  logic                          hsel,
  input  logic [1:0]                    htrans,
  input  logic                          hwrite,
  input  logic [`BRIDGE_DATA_W-1:0]     haddr,
  input  logic [`BRIDGE_DATA_W-1:0]     hwdata,
  output logic [`BRIDGE_DATA_W-1:0]     hrdata,
  output logic                          hready,

  // APB master interface
  output bridge_pkg::apb_ctrl_t         apb,
  output logic [`BRIDGE_DATA_W-1:0]     pwdata,
  output logic [`BRIDGE_NUM_SLAVES-1:0] psel,
  input  bridge_pkg::apb_resp_t         resp [`BRIDGE_NUM_SLAVES]
);

  bridge_pkg::ahb_req_t          req;
  logic                          req_valid;
  logic [`BRIDGE_NUM_SLAVES-1:0] psel_vec;
  logic                          done;
  logic [`BRIDGE_DATA_W-1:0]     done_rdata;
  logic                          sel_ready;
  logic [`BRIDGE_DATA_W-1:0]     sel_rdata;

  // Master keeps hwdata stable through the stall
  assign pwdata = hwdata;

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------

  ahb_capture ahb_capture_i (
    .hclk28     (hclk28),
    .hreset_n28 (hreset_n28),
    .hsel       (hsel),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .haddr      (haddr),
    .done       (done),
    .done_rdata (done_rdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .req        (req),
    .req_valid  (req_valid)
  );

  apb_sequencer apb_sequencer_i (
    .hclk28     (hclk28),
    .hreset_n28 (hreset_n28),
    .req        (req),
    .req_valid  (req_valid),
    .sel_ready  (sel_ready),
    .sel_rdata  (sel_rdata),
    .psel_vec   (psel_vec),
    .apb        (apb),
    .done       (done),
    .done_rdata (done_rdata)
  );

  apb_port_mux apb_port_mux_i (
    .psel_vec  (psel_vec),
    .resp      (resp),
    .psel      (psel),
    .sel_ready (sel_ready),
    .sel_rdata (sel_rdata)
  );

endmodule

//--- design/ahb_capture.sv
// AHB slave side of the bridge; qualifies and decodes one transfer and stalls hready until it ends
`timescale 1ns/100ps
`include "bridge_settings.svh"

module ahb_capture (
  input  logic                      hclk28,
  input  logic                      hreset_n28,
  input  logic                      hsel,
  input  logic [1:0]                htrans,
  input  logic                      hwrite,
  input  logic [`BRIDGE_DATA_W-1:0] haddr,
  input  logic                      done,
  input  logic [`BRIDGE_DATA_W-1:0] done_rdata,
  output logic                      hready,
  output logic [`BRIDGE_DATA_W-1:0] hrdata,
  output bridge_pkg::ahb_req_t      req,
  output logic                      req_valid
);

  // Transfer types that carry data
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  bridge_pkg::ahb_addr_u         addr_in;
  logic                          accept;
  logic                          hit;
  logic [`BRIDGE_NUM_SLAVES-1:0] sel_dec;

  // ----------------------------------------------------------
  // Address phase qualification and decode
  // ----------------------------------------------------------

  // IDLE and BUSY are ignored, as is anything during a stall
  assign accept = hready && hsel &&
                  ((htrans == htrans_nonseq) || (htrans == htrans_seq));

  assign addr_in.word = haddr;

  assign hit = (addr_in.fields.tag == `BRIDGE_REGION_TAG);

  // One-hot slave select, empty on a miss
  always_comb begin
    sel_dec = '0;
    if (hit) begin
      sel_dec[addr_in.fields.slot] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Data phase
  // ----------------------------------------------------------

  // Request fields only matter while req_valid is high
  always_ff @(posedge hclk28) begin
    if (accept) begin
      req.addr  <= addr_in;
      req.write <= hwrite;
      req.hit   <= hit;
      req.sel   <= sel_dec;
    end
  end

  // Set on accept, cleared on the edge that completes the transfer
  always_ff @(posedge hclk28 or negedge hreset_n28) begin
    if (!hreset_n28) begin
      req_valid <= 1'b0;
    end else if (accept) begin
      req_valid <= 1'b1;
    end else if (done) begin
      req_valid <= 1'b0;
    end
  end

  // Bus is stalled for the whole data phase
  assign hready = ~req_valid;

  // Read data is held until the next completion
  always_ff @(posedge hclk28 or negedge hreset_n28) begin
    if (!hreset_n28) begin
      hrdata <= '0;
    end else if (done) begin
      hrdata <= done_rdata;
    end
  end

endmodule

//--- design/apb_port_mux.sv
// APB slave port fan-out; drives each psel and merges the selected slave's pready and prdata
`timescale 1ns/100ps
`include "bridge_settings.svh"

module apb_port_mux (
  input  logic [`BRIDGE_NUM_SLAVES-1:0] psel_vec,
  input  bridge_pkg::apb_resp_t         resp [`BRIDGE_NUM_SLAVES],
  output logic [`BRIDGE_NUM_SLAVES-1:0] psel,
  output logic                          sel_ready,
  output logic [`BRIDGE_DATA_W-1:0]     sel_rdata
);

  logic                      ready_acc;
  logic [`BRIDGE_DATA_W-1:0] rdata_acc;

  // ----------------------------------------------------------
  // Select fan-out
  // ----------------------------------------------------------

  // One psel line per slave
  assign psel = psel_vec;

  // ----------------------------------------------------------
  // Response merge
  // ----------------------------------------------------------

  // AND-OR merge, unselected slaves contribute nothing
  always_comb begin
    ready_acc = 1'b0;
    rdata_acc = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      ready_acc = ready_acc | (psel_vec[i] & resp[i].pready);
      rdata_acc = rdata_acc | ({`BRIDGE_DATA_W{psel_vec[i]}} & resp[i].prdata);
    end
  end

  assign sel_ready = ready_acc;
  assign sel_rdata = rdata_acc;

endmodule

//--- design/apb_sequencer.sv
// APB master state machine; runs setup and access for a captured request and signals completion
`timescale 1ns/100ps
`include "bridge_settings.svh"

module apb_sequencer (
  input  logic                          hclk28,
  input  logic                          hreset_n28,
  input  bridge_pkg::ahb_req_t          req,
  input  logic                          req_valid,
  input  logic                          sel_ready,
  input  logic [`BRIDGE_DATA_W-1:0]     sel_rdata,
  output logic [`BRIDGE_NUM_SLAVES-1:0] psel_vec,
  output bridge_pkg::apb_ctrl_t         apb,
  output logic                          done,
  output logic [`BRIDGE_DATA_W-1:0]     done_rdata
);

  // One-hot APB phases
  typedef enum logic [2:0] {
    st_idle   = 3'b001,
    st_setup  = 3'b010,
    st_access = 3'b100
  } state_t;

  state_t state_q;
  logic   in_idle;
  logic   in_access;
  logic   miss;

  assign in_idle   = (state_q == st_idle);
  assign in_access = (state_q == st_access);

  // ----------------------------------------------------------
  // Completion
  // ----------------------------------------------------------

  // Outside the region, finish straight from idle
  assign miss = in_idle && req_valid && !req.hit;

  assign done = miss || (in_access && sel_ready);

  // Misses read as zero
  assign done_rdata = in_access ? sel_rdata : '0;

  // ----------------------------------------------------------
  // Phase sequencing
  // ----------------------------------------------------------

  always_ff @(posedge hclk28 or negedge hreset_n28) begin
    if (!hreset_n28) begin
      state_q  <= st_idle;
      psel_vec <= '0;
      apb      <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          // Setup phase: select and address out, penable still low
          if (req_valid && req.hit) begin
            state_q    <= st_setup;
            psel_vec   <= req.sel;
            apb.paddr  <= req.addr.word;
            apb.pwrite <= req.write;
          end
        end

        st_setup: begin
          state_q     <= st_access;
          apb.penable <= 1'b1;
        end

        st_access: begin
          // Slave wait states hold us here
          if (sel_ready) begin
            state_q     <= st_idle;
            psel_vec    <= '0;
            apb.penable <= 1'b0;
          end
        end

        default: begin
          state_q     <= st_idle;
          psel_vec    <= '0;
          apb.penable <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- design/bridge_pkg.sv
// Shared bridge types: address views, captured request and APB control and response bundles
`include "bridge_settings.svh"

package bridge_pkg;

  // ----------------------------------------------------------
  // Address decoding
  // ----------------------------------------------------------

  // Field view of an AHB address inside the APB map
  typedef struct packed {
    logic [`BRIDGE_TAG_W-1:0]    tag;
    logic [`BRIDGE_SLOT_W-1:0]   slot;
    logic [`BRIDGE_OFFSET_W-1:0] offset;
  } ahb_addr_fields_t;

  // Raw word goes to paddr, fields feed the decoder
  typedef union packed {
    logic [`BRIDGE_DATA_W-1:0] word;
    ahb_addr_fields_t          fields;
  } ahb_addr_u;

  // ----------------------------------------------------------
  // Bundles between blocks
  // ----------------------------------------------------------

  // Request held for the whole AHB data phase
  typedef struct packed {
    ahb_addr_u                     addr;
    logic                          write;
    logic                          hit;
    logic [`BRIDGE_NUM_SLAVES-1:0] sel;
  } ahb_req_t;

  // APB signals common to every slave
  typedef struct packed {
    logic [`BRIDGE_DATA_W-1:0] paddr;
    logic                      pwrite;
    logic                      penable;
  } apb_ctrl_t;

  // Response of one APB slave
  typedef struct packed {
    logic                      pready;
    logic [`BRIDGE_DATA_W-1:0] prdata;
  } apb_resp_t;

endpackage

//--- design/bridge_settings.svh
// Bus widths, slave count and APB address map of the bridge, included by every file that sizes a port
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------

// AHB and APB address and data width
`define BRIDGE_DATA_W 32

// ----------------------------------------------------------
// Slave map
// ----------------------------------------------------------

// Number of APB slaves, one psel bit each
`define BRIDGE_NUM_SLAVES 4

// Address bits that pick the slave window
`define BRIDGE_SLOT_W 2

// Byte offset inside one 4 KB window
`define BRIDGE_OFFSET_W 12

// Upper address bits left over once slot and offset are taken
`define BRIDGE_TAG_W (`BRIDGE_DATA_W - `BRIDGE_SLOT_W - `BRIDGE_OFFSET_W)

// Tag of the APB region, base 0x4000_0000
`define BRIDGE_REGION_TAG 18'h10000

`endif

//--- verification/tb_ahb_apb_bridge.sv
// Self-checking testbench for the AHB-to-APB bridge; runs a transfer table against four APB slaves
`timescale 1ns/100ps
`include "bridge_settings.svh"

// Behavioral APB slave with 16 words and a programmable number of wait states
module apb_slave_model #(
  parameter int slave_id = 0
) (
  input  logic                      hclk28,
  input  logic                      hreset_n28,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`BRIDGE_DATA_W-1:0] paddr,
  input  logic [`BRIDGE_DATA_W-1:0] pwdata,
  input  logic [2:0]                waits,
  output bridge_pkg::apb_resp_t     resp
);

  logic [`BRIDGE_DATA_W-1:0] mem [16];
  logic [2:0]                wait_cnt;

  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = '0;
    end
  end

  // Wait count loaded in setup, counted down in access
  always_ff @(posedge hclk28 or negedge hreset_n28) begin
    if (!hreset_n28) begin
      wait_cnt <= 3'd0;
    end else if (psel && !penable) begin
      wait_cnt <= waits;
    end else if (psel && penable && (wait_cnt != 3'd0)) begin
      wait_cnt <= wait_cnt - 3'd1;
    end
  end

  assign resp.pready = psel && penable && (wait_cnt == 3'd0);

  // Junk outside access so the bridge merge must mask it
  assign resp.prdata = (psel && penable) ? mem[paddr[5:2]] :
                       (32'hbad0_0000 | 32'(slave_id));

  always @(posedge hclk28) begin
    if (psel && penable && resp.pready && pwrite) begin
      mem[paddr[5:2]] <= pwdata;
    end
  end

endmodule

module tb_ahb_apb_bridge;

  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_busy   = 2'b01;
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;
  localparam int         hready_limit  = 50;

  // One table row: stimulus plus expected read data
  typedef struct packed {
    logic        hsel;
    logic [1:0]  htrans;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [2:0]  waits;
    logic [31:0] rdata;
  } xfer_t;

  logic                          hclk28;
  logic                          hreset_n28;
  logic                          hsel;
  logic [1:0]                    htrans;
  logic                          hwrite;
  logic [`BRIDGE_DATA_W-1:0]     haddr;
  logic [`BRIDGE_DATA_W-1:0]     hwdata;
  logic [`BRIDGE_DATA_W-1:0]     hrdata;
  logic                          hready;
  bridge_pkg::apb_ctrl_t         apb;
  logic [`BRIDGE_DATA_W-1:0]     pwdata;
  logic [`BRIDGE_NUM_SLAVES-1:0] psel;
  bridge_pkg::apb_resp_t         resp [`BRIDGE_NUM_SLAVES];
  logic [2:0]                    slave_waits;

  xfer_t       table_q [$];
  logic [31:0] mirror [64];
  logic [31:0] rng_state;
  int          error_count;
  int          timeout_count;
  logic        timed_out;

  ahb_apb_bridge ahb_apb_bridge_i (
    .hclk28     (hclk28),
    .hreset_n28 (hreset_n28),
    .hsel       (hsel),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .haddr      (haddr),
    .hwdata     (hwdata),
    .hrdata     (hrdata),
    .hready     (hready),
    .apb        (apb),
    .pwdata     (pwdata),
    .psel       (psel),
    .resp       (resp)
  );

  for (genvar g = 0; g < `BRIDGE_NUM_SLAVES; g++) begin : g_slave
    apb_slave_model #(.slave_id(g)) slave_i (
      .hclk28     (hclk28),
      .hreset_n28 (hreset_n28),
      .psel       (psel[g]),
      .penable    (apb.penable),
      .pwrite     (apb.pwrite),
      .paddr      (apb.paddr),
      .pwdata     (pwdata),
      .waits      (slave_waits),
      .resp       (resp[g])
    );
  end

  initial begin
    hclk28 = 1'b0;
    forever #20 hclk28 = ~hclk28;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic in_region(input logic [31:0] addr);
    return addr[31:14] == `BRIDGE_REGION_TAG;
  endfunction

  // Mirror follows every accepted write that lands in a slave
  task automatic add_entry(input logic sel, input logic [1:0] trans, input logic wr,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [2:0] waits, input logic [31:0] rdata);
    xfer_t t;
    t = '{sel, trans, wr, addr, wdata, waits, rdata};
    table_q.push_back(t);
    if (sel && trans[1] && wr && in_region(addr)) begin
      mirror[{addr[13:12], addr[5:2]}] = wdata;
    end
  endtask

  task automatic build_table();
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0]  wr_waits;
    logic [2:0]  rd_waits;
    // Same offset in all four slots
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h4000_0010, 32'h1111_0000, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h4000_1010, 32'h2222_0001, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h4000_2010, 32'h3333_0002, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h4000_3010, 32'h4444_0003, 3'd0, 32'h0);
    // Ignored writes that must not land
    add_entry(1'b0, htrans_nonseq, 1'b1, 32'h4000_0010, 32'hffff_ffff, 3'd0, 32'h0);
    add_entry(1'b1, htrans_idle, 1'b1, 32'h4000_1010, 32'hffff_ffff, 3'd0, 32'h0);
    add_entry(1'b1, htrans_busy, 1'b1, 32'h4000_2010, 32'hffff_ffff, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_0010, 32'h0, 3'd0, 32'h1111_0000);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_1010, 32'h0, 3'd0, 32'h2222_0001);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_2010, 32'h0, 3'd0, 32'h3333_0002);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_3010, 32'h0, 3'd0, 32'h4444_0003);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_203c, 32'h0, 3'd0, 32'h0);
    // Wait states
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h4000_1020, 32'hcafe_0001, 3'd1, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_1020, 32'h0, 3'd2, 32'hcafe_0001);
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h4000_3024, 32'h5a5a_0003, 3'd3, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_3024, 32'h0, 3'd4, 32'h5a5a_0003);
    add_entry(1'b1, htrans_seq, 1'b0, 32'h4000_0010, 32'h0, 3'd0, 32'h1111_0000);
    // Outside the APB region
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h5000_0000, 32'h0, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b1, 32'h0000_1000, 32'hdead_beef, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4001_0000, 32'h0, 3'd0, 32'h0);
    add_entry(1'b1, htrans_nonseq, 1'b0, 32'h4000_1000, 32'h0, 3'd0, 32'h0);
    // Random in-region write and read pairs
    for (int i = 0; i < 24; i++) begin
      rng_state = xorshift32(rng_state);
      addr = {`BRIDGE_REGION_TAG, rng_state[1:0], 6'd0, rng_state[5:2], 2'd0};
      wr_waits = 3'(rng_state[10:8] % 3'd5);
      rd_waits = 3'(rng_state[14:12] % 3'd5);
      rng_state = xorshift32(rng_state);
      data = rng_state;
      add_entry(1'b1, htrans_nonseq, 1'b1, addr, data, wr_waits, 32'h0);
      add_entry(1'b1, htrans_nonseq, 1'b0, addr, 32'h0, rd_waits,
                mirror[{addr[13:12], addr[5:2]}]);
    end
  endtask

  // ----------------------------------------------------------
  // One AHB transfer with APB phase monitoring
  // ----------------------------------------------------------

  task automatic run_transfer(input xfer_t t);
    logic                          hit;
    logic                          accepted;
    logic [`BRIDGE_NUM_SLAVES-1:0] exp_sel;
    logic                          seen_psel;
    int                            exp_cycles;
    int                            low_cycles;
    hit        = in_region(t.addr);
    accepted   = t.hsel && t.htrans[1];
    exp_sel    = (hit && accepted) ? (4'b0001 << t.addr[13:12]) : 4'b0000;
    exp_cycles = !accepted ? 0 : (hit ? 3 + int'(t.waits) : 1);
    // Address phase
    slave_waits = t.waits;
    hsel        = t.hsel;
    htrans      = t.htrans;
    hwrite      = t.write;
    haddr       = t.addr;
    hwdata      = t.wdata;
    @(posedge hclk28);
    #2;
    hsel       = 1'b0;
    htrans     = htrans_idle;
    low_cycles = 0;
    seen_psel  = 1'b0;
    while (!hready && !timed_out) begin
      low_cycles++;
      if (psel != '0) begin
        check_value("psel", 32'(psel), 32'(exp_sel));
        // Setup cycle first, then access
        check_value("penable", 32'(apb.penable), 32'(seen_psel));
        check_value("paddr", apb.paddr, t.addr);
        check_value("pwrite", 32'(apb.pwrite), 32'(t.write));
        if (t.write && apb.penable) begin
          check_value("pwdata", pwdata, t.wdata);
        end
        seen_psel = 1'b1;
      end
      if (low_cycles >= hready_limit) begin
        $display("Timeout: hready stayed low for %0d cycles, address %h",
                 hready_limit, t.addr);
        timed_out = 1'b1;
        timeout_count++;
      end else begin
        @(posedge hclk28);
        #2;
      end
    end
    check_value("hready low cycles", 32'(low_cycles), 32'(exp_cycles));
    check_value("psel seen", 32'(seen_psel), 32'(exp_sel != '0));
    check_value("psel after", 32'(psel), 32'h0);
    check_value("penable after", 32'(apb.penable), 32'h0);
    if (accepted && !t.write) begin
      check_value("hrdata", hrdata, t.rdata);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    hreset_n28    = 1'b0;
    hsel          = 1'b0;
    htrans        = htrans_idle;
    hwrite        = 1'b0;
    haddr         = '0;
    hwdata        = '0;
    slave_waits   = 3'd0;
    error_count   = 0;
    timeout_count = 0;
    timed_out     = 1'b0;
    rng_state     = 32'ha13e_aa8f;
    for (int i = 0; i < 64; i++) begin
      mirror[i] = '0;
    end
    build_table();

    repeat (2) @(posedge hclk28);
    #2;
    hreset_n28 = 1'b1;

    check_value("hready", 32'(hready), 32'h1);
    check_value("psel", 32'(psel), 32'h0);
    check_value("penable", 32'(apb.penable), 32'h0);
    check_value("pwrite", 32'(apb.pwrite), 32'h0);
    check_value("paddr", apb.paddr, 32'h0);
    check_value("hrdata", hrdata, 32'h0);

    foreach (table_q[i]) begin
      run_transfer(table_q[i]);
      if (timed_out) begin
        break;
      end
    end

    $display("Run complete: %0d transfers, %0d errors, %0d timeouts",
             table_q.size(), error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
